// ==== project.f ====
graph_pkg.sv
edge_stream_decoder.sv
adjacency_map.sv
neighbor_reply_collector.sv
graph_query_top.sv
tb_graph_query.sv

// ==== Makefile ====
VERILATOR  = verilator
VFLAGS     = --binary --timing -Wno-fatal
LINT_FLAGS = --lint-only -Wall --timing
TOP        = tb_graph_query
RTL_TOP    = graph_query_top
FILELIST   = project.f
OBJ_DIR    = obj_dir
PASS_MSG   = Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only if the pass message appears as a line of its own
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_graph_query.sv ====
`timescale 1ns/100ps

module tb_graph_query;
    import graph_pkg::*;

    localparam int max_nodes    = 64;
    localparam int max_edges    = 256;
    localparam int max_list     = 6;
    localparam int node_width   = $clog2(max_nodes);
    localparam int degree_width = $clog2(max_edges + 1);
    localparam int beat_bound   = 12;  // cycles per reply beat, stalls included.

    logic                         clk;
    logic                         rst;
    logic                         word_valid;
    edge_word_u                   word;
    logic                         stream_end;
    logic                         query_valid;
    logic [node_width-1:0]        query_data;
    logic                         out_ready;
    logic                         protocol_error;
    logic                         decoding_done;
    logic                         query_ready;
    logic                         out_valid;
    logic [stream_node_width-1:0] out_node;
    logic                         out_last;
    logic                         out_empty;
    logic [degree_width-1:0]      out_degree;

    // generated graph, kept in load order.
    bit          loaded [max_nodes];
    int          degree [max_nodes];
    int          dst [max_nodes][max_list];
    int          src_order [max_nodes];
    int          n_src;
    int          total_edges;
    logic [31:0] gen_state;
    bit          graph_built;
    bit          load_phase;
    bit          random_ready;
    int          errors;
    int          checks;

    // expected output beats, oldest first.
    logic [15:0] exp_node [$];
    bit          exp_last [$];
    bit          exp_empty [$];
    int          exp_degree [$];
    logic [15:0] e_node;
    bit          e_last;
    bit          e_empty;
    int          e_degree;

    graph_query_top #(
        .max_nodes      (max_nodes),
        .max_edges      (max_edges)
    ) u_dut (
        .clk            (clk),
        .rst            (rst),
        .word_valid     (word_valid),
        .word           (word),
        .stream_end     (stream_end),
        .query_valid    (query_valid),
        .query_data     (query_data),
        .out_ready      (out_ready),
        .protocol_error (protocol_error),
        .decoding_done  (decoding_done),
        .query_ready    (query_ready),
        .out_valid      (out_valid),
        .out_node       (out_node),
        .out_last       (out_last),
        .out_empty      (out_empty),
        .out_degree     (out_degree)
    );

    always begin
        clk = 1'b0;
        #10;
        clk = 1'b1;
        #10;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic next_random(input int range, output int value);
        gen_state = lcg_step(gen_state);
        value = int'(gen_state[30:16]) % range;  // upper bits repeat less often.
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            $display("FAILED %s: got 0x%h, expected 0x%h at %0t", name, actual, expected, $time);
            errors++;
        end
    endtask

    // expected beats of one query, straight from the generated graph.
    function automatic void reference_reply(input int node);
        int k;
        if (!loaded[node] || degree[node] == 0) begin
            exp_node.push_back(16'd0);
            exp_last.push_back(1'b1);
            exp_empty.push_back(1'b1);
            exp_degree.push_back(0);
        end else begin
            for (k = 0; k < degree[node]; k++) begin
                exp_node.push_back(16'(dst[node][k]));
                exp_last.push_back(k == degree[node] - 1);
                exp_empty.push_back(1'b0);
                exp_degree.push_back(degree[node]);
            end
        end
    endfunction

    task automatic build_graph();
        int i;
        int k;
        int node;
        int cnt;
        n_src       = 0;
        total_edges = 0;
        for (i = 0; i < max_nodes; i++) begin
            loaded[i] = 1'b0;
            degree[i] = 0;
        end
        for (i = 0; i < 48; i++) begin
            next_random(max_nodes, node);
            next_random(max_list + 1, cnt);
            if (!loaded[node] && total_edges + cnt < max_edges) begin
                loaded[node]     = 1'b1;
                degree[node]     = cnt;
                src_order[n_src] = node;
                n_src++;
                total_edges += cnt;
                for (k = 0; k < cnt; k++) begin
                    next_random(max_nodes, dst[node][k]);
                end
            end
        end
    endtask

    task automatic verify_load_idle();
        check_value("query_ready", 32'(query_ready), 32'd0);
        check_value("out_valid", 32'(out_valid), 32'd0);
        check_value("decoding_done", 32'(decoding_done), 32'd0);
        check_value("protocol_error", 32'(protocol_error), 32'd0);
    endtask

    task automatic send_word(input edge_word_u w);
        @(negedge clk);
        if (load_phase) begin
            verify_load_idle();
        end
        word_valid = 1'b1;
        word       = w;
    endtask

    task automatic load_graph();
        edge_word_u w;
        int i;
        int k;
        int node;
        load_phase = 1'b1;
        for (i = 0; i < n_src; i++) begin
            node       = src_order[i];
            w          = '0;
            w.hdr.tag   = tag_header;
            w.hdr.count = stream_count_width'(degree[node]);
            w.hdr.node  = stream_node_width'(node);
            send_word(w);
            for (k = 0; k < degree[node]; k++) begin
                w          = '0;
                w.edg.tag  = tag_edge;
                w.edg.node = stream_node_width'(dst[node][k]);
                send_word(w);
            end
        end
        @(negedge clk);
        verify_load_idle();
        word_valid = 1'b0;
        stream_end = 1'b1;
        @(negedge clk);
        stream_end = 1'b0;
        load_phase = 1'b0;
        check_value("decoding_done", 32'(decoding_done), 32'd1);
        check_value("protocol_error", 32'(protocol_error), 32'd0);
        k = 0;
        while (!query_ready && k < 4) begin
            @(negedge clk);
            k++;
        end
        if (!query_ready) begin
            $display("query_ready did not rise after decoding finished");
            errors++;
        end
    endtask

    task automatic send_query(input int node);
        @(negedge clk);
        query_valid = 1'b1;
        query_data  = node_width'(node);
        while (!query_ready) begin
            @(negedge clk);
        end
        @(negedge clk);  // taken on the posedge just passed.
        query_valid = 1'b0;
    endtask

    task automatic run_queries();
        int node;
        for (node = 0; node < max_nodes; node++) begin
            send_query(node);
        end
        while (exp_node.size() != 0) begin
            @(negedge clk);
        end
        repeat (3) @(negedge clk);  // room for stray beats.
    endtask

    task automatic error_stream();
        edge_word_u w;
        int i;
        @(negedge clk);
        rst = 1'b1;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        check_value("query_ready", 32'(query_ready), 32'd0);
        check_value("out_valid", 32'(out_valid), 32'd0);
        check_value("out_last", 32'(out_last), 32'd0);
        check_value("decoding_done", 32'(decoding_done), 32'd0);
        check_value("protocol_error", 32'(protocol_error), 32'd0);
        w          = '0;
        w.edg.tag  = tag_edge;
        w.edg.node = 16'd5;
        send_word(w);  // edge word without an open header.
        @(negedge clk);
        word_valid = 1'b0;
        check_value("protocol_error", 32'(protocol_error), 32'd1);
        w           = '0;
        w.hdr.tag   = tag_header;
        w.hdr.count = 15'd1;
        w.hdr.node  = 16'd3;
        send_word(w);
        @(negedge clk);
        word_valid = 1'b0;
        stream_end = 1'b1;
        @(negedge clk);
        stream_end = 1'b0;
        for (i = 0; i < 4; i++) begin
            @(negedge clk);
            check_value("protocol_error", 32'(protocol_error), 32'd1);
        end
    endtask

    // output back-pressure from its own generator state.
    initial begin
        logic [31:0] ready_state;
        ready_state = 32'd85053;
        out_ready   = 1'b1;
        forever begin
            @(negedge clk);
            ready_state = lcg_step(ready_state);
            out_ready   = !random_ready || (ready_state[29:28] != 2'b00);
        end
    end

    always @(posedge clk) begin
        if (!rst && out_valid && out_ready) begin
            if (exp_node.size() == 0) begin
                $display("output beat with node 0x%h arrived while no reply was expected",
                         out_node);
                errors++;
            end else begin
                e_node   = exp_node.pop_front();
                e_last   = exp_last.pop_front();
                e_empty  = exp_empty.pop_front();
                e_degree = exp_degree.pop_front();
                if (!e_empty) begin
                    check_value("out_node", 32'(out_node), 32'(e_node));
                end
                check_value("out_last", 32'(out_last), 32'(e_last));
                check_value("out_empty", 32'(out_empty), 32'(e_empty));
                if (e_last) begin
                    check_value("out_degree", 32'(out_degree), 32'(e_degree));
                end
            end
        end
        // only the final beat may still be in flight once a new query is allowed.
        if (!rst && query_ready && exp_node.size() > 1) begin
            $display("query_ready was high while a reply list was still open at %0t", $time);
            errors++;
        end
        if (!rst && query_valid && query_ready) begin
            reference_reply(int'(query_data));
        end
    end

    initial begin
        int limit;
        wait (graph_built);
        limit = 2 * (n_src + total_edges) + 2 * max_nodes * max_list * beat_bound + 200;
        repeat (limit) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", limit);
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("Something failed");
        $finish;
    end

    initial begin
        rst          = 1'b1;
        word_valid   = 1'b0;
        word         = '0;
        stream_end   = 1'b0;
        query_valid  = 1'b0;
        query_data   = '0;
        random_ready = 1'b0;
        load_phase   = 1'b0;
        graph_built  = 1'b0;
        errors       = 0;
        checks       = 0;
        gen_state    = 32'd85053;
        build_graph();
        graph_built = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_value("out_last", 32'(out_last), 32'd0);
        load_graph();
        run_queries();
        random_ready = 1'b1;
        run_queries();
        random_ready = 1'b0;
        error_stream();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== graph_query_top.sv ====
`timescale 1ns/100ps

module graph_query_top #(
    parameter int max_nodes = 64,
    parameter int max_edges = 256
) (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    word_valid,
    input  graph_pkg::edge_word_u                   word,
    input  logic                                    stream_end,
    input  logic                                    query_valid,
    input  logic [$clog2(max_nodes)-1:0]            query_data,
    input  logic                                    out_ready,
    output logic                                    protocol_error,
    output logic                                    decoding_done,
    output logic                                    query_ready,
    output logic                                    out_valid,
    output logic [graph_pkg::stream_node_width-1:0] out_node,
    output logic                                    out_last,
    output logic                                    out_empty,
    output logic [$clog2(max_edges+1)-1:0]          out_degree
);
    import graph_pkg::*;

    localparam int node_width = $clog2(max_nodes);

    logic                         src_node_valid;
    logic                         edge_valid;
    logic [node_width-1:0]        src_node;
    logic [node_width-1:0]        dst_node;
    logic                         reply_valid;
    logic                         reply_ready;
    logic [node_width-1:0]        reply_data;
    logic                         reply_last;
    logic                         reply_no_edges_found;
    logic [stream_node_width-1:0] reply_node;

    edge_stream_decoder #(
        .max_nodes      (max_nodes)
    ) u_decoder (
        .clk            (clk),
        .rst            (rst),
        .word_valid     (word_valid),
        .word           (word),
        .stream_end     (stream_end),
        .src_node_valid (src_node_valid),
        .edge_valid     (edge_valid),
        .src_node       (src_node),
        .dst_node       (dst_node),
        .decoding_done  (decoding_done),
        .protocol_error (protocol_error)
    );

    adjacency_map #(
        .max_nodes            (max_nodes),
        .max_edges            (max_edges)
    ) u_map (
        .clk                  (clk),
        .rst                  (rst),
        .decoding_done        (decoding_done),
        .edge_valid           (edge_valid),
        .src_node_valid       (src_node_valid),
        .src_node             (src_node),
        .dst_node             (dst_node),
        .query_ready          (query_ready),
        .query_valid          (query_valid),
        .query_data           (query_data),
        .reply_last           (reply_last),
        .reply_ready          (reply_ready),
        .reply_valid          (reply_valid),
        .reply_data           (reply_data),
        .reply_no_edges_found (reply_no_edges_found)
    );

    // replies leave at the stream's node width.
    assign reply_node = stream_node_width'(reply_data);

    neighbor_reply_collector #(
        .max_edges            (max_edges)
    ) u_collector (
        .clk                  (clk),
        .rst                  (rst),
        .reply_valid          (reply_valid),
        .reply_data           (reply_node),
        .reply_last           (reply_last),
        .reply_no_edges_found (reply_no_edges_found),
        .out_ready            (out_ready),
        .reply_ready          (reply_ready),
        .out_valid            (out_valid),
        .out_node             (out_node),
        .out_last             (out_last),
        .out_empty            (out_empty),
        .out_degree           (out_degree)
    );

endmodule

// ==== neighbor_reply_collector.sv ====
`timescale 1ns/100ps

module neighbor_reply_collector #(
    parameter int max_edges = 256
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  reply_valid,
    input  logic [graph_pkg::stream_node_width-1:0] reply_data,
    input  logic                                  reply_last,
    input  logic                                  reply_no_edges_found,
    input  logic                                  out_ready,
    output logic                                  reply_ready,
    output logic                                  out_valid,
    output logic [graph_pkg::stream_node_width-1:0] out_node,
    output logic                                  out_last,
    output logic                                  out_empty,
    output logic [$clog2(max_edges+1)-1:0]        out_degree
);

    localparam int degree_width = $clog2(max_edges + 1);

    logic                    reply_take;
    logic                    out_take_last;
    logic [degree_width-1:0] beat_count;
    logic [degree_width-1:0] count_base;
    logic [degree_width-1:0] beat_inc;

    // accept when the register is empty or drains this cycle.
    assign reply_ready   = !out_valid || out_ready;
    assign reply_take    = reply_valid && reply_ready;
    assign out_take_last = out_valid && out_ready && out_last;

    // a finished list restarts the count even when the next list starts now.
    assign count_base = out_take_last ? '0 : beat_count;
    assign beat_inc   = reply_no_edges_found ? '0 : degree_width'(1);

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid  <= 1'b0;
            out_last   <= 1'b0;
            beat_count <= '0;
        end else begin
            if (reply_take) begin
                out_valid  <= 1'b1;
                out_last   <= reply_last;
                beat_count <= count_base + beat_inc;
            end else begin
                beat_count <= count_base;
                if (out_ready) begin
                    out_valid <= 1'b0;
                    out_last  <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reply_take) begin
            out_node  <= reply_data;
            out_empty <= reply_no_edges_found;
            if (reply_last) begin
                out_degree <= count_base + beat_inc;  // zero for an empty node.
            end
        end
    end

endmodule

// ==== adjacency_map.sv ====
`timescale 1ns/100ps

module adjacency_map #(
    parameter int max_nodes = 64,
    parameter int max_edges = 256
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         decoding_done,
    input  logic                         edge_valid,
    input  logic                         src_node_valid,
    input  logic [$clog2(max_nodes)-1:0] src_node,
    input  logic [$clog2(max_nodes)-1:0] dst_node,
    output logic                         query_ready,
    input  logic                         query_valid,
    input  logic [$clog2(max_nodes)-1:0] query_data,
    output logic                         reply_last,
    input  logic                         reply_ready,
    output logic                         reply_valid,
    output logic [$clog2(max_nodes)-1:0] reply_data,
    output logic                         reply_no_edges_found
);

    localparam int node_width     = $clog2(max_nodes);
    localparam int edge_ptr_width = $clog2(max_edges);

    localparam logic [1:0] st_wait_done  = 2'd0;
    localparam logic [1:0] st_wait_query = 2'd1;
    localparam logic [1:0] st_set_ptr    = 2'd2;
    localparam logic [1:0] st_return     = 2'd3;

    // index entry is {first pointer, last pointer}.
    logic [2*edge_ptr_width-1:0] node_index [max_nodes];
    logic [node_width-1:0]       dst_list [max_edges];
    logic [max_nodes-1:0]        has_edges;

    logic [edge_ptr_width-1:0] wr_ptr;
    logic [edge_ptr_width-1:0] base_ptr;
    logic [edge_ptr_width-1:0] rd_ptr;
    logic [edge_ptr_width-1:0] last_ptr;
    logic                      query_has_edges;
    logic                      fetch;
    logic [1:0]                state;
    logic [1:0]                state_next;
    logic                      query_take;
    logic                      reply_take;
    logic                      advance;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            base_ptr  <= '0;
            has_edges <= '0;
        end else if (src_node_valid) begin
            base_ptr <= wr_ptr;  // first edge of the new list.
        end else if (edge_valid) begin
            wr_ptr              <= wr_ptr + 1'b1;
            has_edges[src_node] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (edge_valid) begin
            node_index[src_node] <= {base_ptr, wr_ptr};
            dst_list[wr_ptr]     <= dst_node;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_wait_done;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            st_wait_done: begin
                if (decoding_done) begin
                    state_next = st_wait_query;
                end
            end
            st_wait_query: begin
                if (query_valid) begin
                    state_next = st_set_ptr;
                end
            end
            st_set_ptr: begin
                state_next = st_return;
            end
            st_return: begin
                if (reply_take && reply_last) begin
                    state_next = st_wait_query;
                end
            end
            default: begin
                state_next = st_wait_done;
            end
        endcase
    end

    assign query_ready = (state == st_wait_query);
    assign query_take  = query_valid && query_ready;
    assign reply_take  = reply_valid && reply_ready;
    assign advance     = reply_take && !reply_last && (state == st_return);

    // read pointer holds while the reply waits for reply_ready.
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr          <= '0;
            last_ptr        <= '0;
            query_has_edges <= 1'b0;
        end else if (query_take) begin
            query_has_edges <= has_edges[query_data];
            if (has_edges[query_data]) begin
                {rd_ptr, last_ptr} <= node_index[query_data];
            end else begin
                rd_ptr   <= '0;
                last_ptr <= '0;
            end
        end else if (advance) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch <= 1'b0;
        end else begin
            fetch <= query_take || advance;  // one list read per beat.
        end
    end

    always_ff @(posedge clk) begin
        if (fetch) begin
            reply_data <= query_has_edges ? dst_list[rd_ptr] : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            reply_valid          <= 1'b0;
            reply_last           <= 1'b0;
            reply_no_edges_found <= 1'b0;
        end else if (fetch) begin
            reply_valid          <= 1'b1;
            reply_last           <= !query_has_edges || (rd_ptr == last_ptr);
            reply_no_edges_found <= !query_has_edges;
        end else if (reply_take) begin
            reply_valid <= 1'b0;
            reply_last  <= 1'b0;
        end
    end

endmodule

// ==== edge_stream_decoder.sv ====
`timescale 1ns/100ps

module edge_stream_decoder #(
    parameter int max_nodes = 64
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         word_valid,
    input  graph_pkg::edge_word_u        word,
    input  logic                         stream_end,
    output logic                         src_node_valid,
    output logic                         edge_valid,
    output logic [$clog2(max_nodes)-1:0] src_node,
    output logic [$clog2(max_nodes)-1:0] dst_node,
    output logic                         decoding_done,
    output logic                         protocol_error
);
    import graph_pkg::*;

    localparam int node_width = $clog2(max_nodes);

    logic [stream_count_width-1:0] edges_left;
    logic                          is_header;
    logic                          is_edge;
    logic                          late_word;
    logic                          bad_header;
    logic                          bad_edge;
    logic                          take_header;
    logic                          take_edge;

    // the tag decides which view of the word is valid.
    assign late_word   = word_valid && decoding_done;
    assign is_header   = word_valid && !decoding_done && (word.hdr.tag == tag_header);
    assign is_edge     = word_valid && !decoding_done && (word.edg.tag == tag_edge);
    assign bad_header  = is_header && (edges_left != '0);  // previous list still open.
    assign bad_edge    = is_edge && (edges_left == '0);    // no open header.
    assign take_header = is_header && !bad_header;
    assign take_edge   = is_edge && !bad_edge;

    always_ff @(posedge clk) begin
        if (rst) begin
            edges_left     <= '0;
            src_node_valid <= 1'b0;
            edge_valid     <= 1'b0;
        end else begin
            src_node_valid <= 1'b0;
            edge_valid     <= 1'b0;
            if (take_header) begin
                edges_left     <= word.hdr.count;
                src_node_valid <= (word.hdr.count != '0);  // empty lists get no entry.
            end else if (take_edge) begin
                edges_left <= edges_left - 1'b1;
                edge_valid <= 1'b1;
            end
        end
    end

    // source node is held across all edge words of its list.
    always_ff @(posedge clk) begin
        if (take_header) begin
            src_node <= word.hdr.node[node_width-1:0];
        end
        if (take_edge) begin
            dst_node <= word.edg.node[node_width-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            decoding_done  <= 1'b0;
            protocol_error <= 1'b0;
        end else begin
            if (stream_end) begin
                decoding_done <= 1'b1;  // sticky until reset.
            end
            if (late_word || bad_header || bad_edge) begin
                protocol_error <= 1'b1;
            end
        end
    end

endmodule

// ==== graph_pkg.sv ====
package graph_pkg;

    localparam int stream_word_width  = 32;
    localparam int stream_node_width  = 16;  // limits max_nodes to 2**16.
    localparam int stream_count_width = 15;

    localparam logic tag_header = 1'b1;
    localparam logic tag_edge   = 1'b0;

    // one stream word, either a header or an edge.
    typedef union packed {
        struct packed {
            logic                          tag;    // tag_header.
            logic [stream_count_width-1:0] count;  // edge words that follow.
            logic [stream_node_width-1:0]  node;   // source node.
        } hdr;
        struct packed {
            logic                                            tag;     // tag_edge.
            logic [stream_word_width-stream_node_width-2:0]  unused;
            logic [stream_node_width-1:0]                    node;    // destination node.
        } edg;
    } edge_word_u;

endpackage
